// ==== include/dynaq_params.svh ====
`ifndef DYNAQ_PARAMS_SVH
`define DYNAQ_PARAMS_SVH

// grid and reward widths
`define DQ_LOCATION_W 6
`define DQ_REWARD_W 11
`define DQ_STEP_W 10

// q-values are signed fixed point with 16 fraction bits
`define DQ_DATA_W 64
`define DQ_FRAC_W 16

// discount factor, about 0.85 in q16
`define DQ_GAMMA 55705

// exploration threshold and random word share one width
`define DQ_EPSILON_W 17
`define DQ_EPSILON_START 120
`define DQ_EPSILON_DEC 10

// episode length limit and lfsr start value
`define DQ_MAX_STEPS 1023
`define DQ_LFSR_SEED 1

`endif

// ==== hw/dynaq_data_pkg.sv ====
`include "dynaq_params.svh"

package dynaq_data_pkg;

  // one grid cell
  typedef logic [`DQ_LOCATION_W-1:0] location_t;

  // signed reward from the environment
  // goal reward has all lower ten bits set
  typedef logic signed [`DQ_REWARD_W-1:0] reward_t;

  // signed q16 value
  typedef logic signed [`DQ_DATA_W-1:0] qvalue_t;

endpackage

// ==== hw/dynaq_policy_pkg.sv ====
`include "dynaq_params.svh"

package dynaq_policy_pkg;

  // move 0 to 3
  typedef logic [1:0] action_t;

  // exploration threshold
  typedef logic [`DQ_EPSILON_W-1:0] epsilon_t;

  // steps taken in this episode
  typedef logic [`DQ_STEP_W-1:0] step_t;

  // lfsr word
  typedef logic [`DQ_EPSILON_W-1:0] rand_t;

endpackage

// ==== hw/state_capture.sv ====
`timescale 1ns/100ps

module state_capture (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        qvalue_en,
  input  logic                        reward_en,
  input  logic                        current_location_en,
  input  logic                        next_location_en,
  input  logic                        location_select,
  input  dynaq_data_pkg::location_t   start_location,
  input  dynaq_data_pkg::location_t   env_next_location,
  input  dynaq_data_pkg::qvalue_t     qvalue_0,
  input  dynaq_data_pkg::qvalue_t     qvalue_1,
  input  dynaq_data_pkg::qvalue_t     qvalue_2,
  input  dynaq_data_pkg::qvalue_t     qvalue_3,
  input  dynaq_data_pkg::reward_t     reward,
  output dynaq_data_pkg::location_t   current_location,
  output dynaq_data_pkg::location_t   next_location,
  output dynaq_data_pkg::qvalue_t     q_0,
  output dynaq_data_pkg::qvalue_t     q_1,
  output dynaq_data_pkg::qvalue_t     q_2,
  output dynaq_data_pkg::qvalue_t     q_3,
  output dynaq_data_pkg::reward_t     reward_q
);

  import dynaq_data_pkg::*;

  location_t current_location_d;
  location_t next_location_d;

  // select 0 starts an episode at the start cell
  // select 1 moves one cell forward
  assign current_location_d = location_select ? next_location : start_location;
  assign next_location_d    = location_select ? env_next_location : start_location;

  // q-values of the current state, all four actions
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      q_0 <= '0;
      q_1 <= '0;
      q_2 <= '0;
      q_3 <= '0;
    end else if (qvalue_en) begin
      q_0 <= qvalue_0;
      q_1 <= qvalue_1;
      q_2 <= qvalue_2;
      q_3 <= qvalue_3;
    end
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      reward_q <= '0;
    end else if (reward_en) begin
      reward_q <= reward;
    end
  end

  // location pair, separate enables
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      current_location <= '0;
      next_location    <= '0;
    end else begin
      if (current_location_en)
        current_location <= current_location_d;
      if (next_location_en)
        next_location <= next_location_d;
    end
  end

endmodule

// ==== hw/q_update.sv ====
`timescale 1ns/100ps

`include "dynaq_params.svh"

module q_update (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          max_en,
  input  logic                          g_en,
  input  logic                          g_select,
  input  dynaq_data_pkg::qvalue_t       q_0,
  input  dynaq_data_pkg::qvalue_t       q_1,
  input  dynaq_data_pkg::qvalue_t       q_2,
  input  dynaq_data_pkg::qvalue_t       q_3,
  input  dynaq_data_pkg::reward_t       reward_q,
  output dynaq_policy_pkg::action_t     greedy_action,
  output dynaq_data_pkg::qvalue_t       qtable_data
);

  import dynaq_data_pkg::*;

  localparam qvalue_t gamma_q = qvalue_t'(`DQ_GAMMA);

  qvalue_t max_01;
  qvalue_t max_23;
  qvalue_t max_value;
  qvalue_t max_q;
  qvalue_t reward_ext;
  qvalue_t product;
  qvalue_t sum;
  logic    pick_1;
  logic    pick_3;
  logic    pick_hi;
  logic signed [2*`DQ_DATA_W-1:0] product_full;
  logic signed [2*`DQ_DATA_W-1:0] product_shift;

  // two-level signed compare tree
  // strict greater-than so ties keep the lower index
  assign pick_1  = q_1 > q_0;
  assign pick_3  = q_3 > q_2;
  assign max_01  = pick_1 ? q_1 : q_0;
  assign max_23  = pick_3 ? q_3 : q_2;
  assign pick_hi = max_23 > max_01;

  assign max_value     = pick_hi ? max_23 : max_01;
  assign greedy_action = pick_hi ? {1'b1, pick_3} : {1'b0, pick_1};

  // gamma times max in full width then back to q16
  assign product_full  = max_q * gamma_q;
  assign product_shift = product_full >>> `DQ_FRAC_W;
  assign product       = product_shift[`DQ_DATA_W-1:0];

  // integer reward aligned to the q16 point
  assign reward_ext = qvalue_t'(reward_q);
  // wraps on overflow
  assign sum        = (reward_ext <<< `DQ_FRAC_W) + qtable_data;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      max_q <= '0;
    end else if (max_en) begin
      max_q <= max_value;
    end
  end

  // target takes the product first and then the reward on top
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      qtable_data <= '0;
    end else if (g_en) begin
      qtable_data <= g_select ? sum : product;
    end
  end

  // target source must be known whenever it loads
  a_g_select_known: assert property (
    @(posedge clk) disable iff (!reset) g_en |-> !$isunknown(g_select));

endmodule

// ==== hw/action_select.sv ====
`timescale 1ns/100ps

`include "dynaq_params.svh"

module action_select (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          rng_en,
  input  logic                          action_en,
  input  dynaq_policy_pkg::action_t     greedy_action,
  input  dynaq_policy_pkg::epsilon_t    epsilon,
  output dynaq_policy_pkg::action_t     action
);

  import dynaq_policy_pkg::*;

  rand_t   lfsr;
  logic    feedback;
  logic    explore;
  action_t random_action;
  action_t next_action;

  // fibonacci taps 17 and 14
  assign feedback = lfsr[16] ^ lfsr[13];

  // low 7 bits against epsilon decide explore vs exploit
  assign explore       = epsilon_t'(lfsr[6:0]) < epsilon;
  // bits 8:7 are independent of the compare bits
  assign random_action = lfsr[8:7];
  assign next_action   = explore ? random_action : greedy_action;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      lfsr <= rand_t'(`DQ_LFSR_SEED);
    end else if (rng_en) begin
      lfsr <= {lfsr[15:0], feedback};
    end
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      action <= '0;
    end else if (action_en) begin
      action <= next_action;
    end
  end

  // all-zero state would lock the lfsr
  a_lfsr_nonzero: assert property (
    @(posedge clk) disable iff (!reset) lfsr != '0);

endmodule

// ==== hw/episode_control.sv ====
`timescale 1ns/100ps

`include "dynaq_params.svh"

module episode_control (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          step_en,
  input  logic                          step_select,
  input  logic                          epsilon_decay_en,
  input  logic                          episode_end,
  input  dynaq_data_pkg::reward_t       reward_q,
  output dynaq_policy_pkg::step_t       step_count,
  output dynaq_policy_pkg::epsilon_t    epsilon,
  output logic                          done,
  output logic                          completed
);

  import dynaq_policy_pkg::*;

  step_t    step_next;
  logic     goal;
  epsilon_t epsilon_dec;

  assign step_next = step_count + step_t'(1);

  // goal reward marked by the low ten bits all set
  assign goal = &reward_q[`DQ_REWARD_W-2:0];
  // episode ends at goal or on the last step
  assign done = goal || (step_next == step_t'(`DQ_MAX_STEPS));

  // saturate at zero
  assign epsilon_dec = (epsilon < epsilon_t'(`DQ_EPSILON_DEC)) ? '0
                     : epsilon - epsilon_t'(`DQ_EPSILON_DEC);

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      step_count <= '0;
    end else if (step_en) begin
      step_count <= step_select ? step_next : '0;
    end
  end

  // less exploring after each goal
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      epsilon <= epsilon_t'(`DQ_EPSILON_START);
    end else if (epsilon_decay_en && goal) begin
      epsilon <= epsilon_dec;
    end
  end

  // sticky until reset
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      completed <= 1'b0;
    end else if ((epsilon == '0) && done && episode_end) begin
      completed <= 1'b1;
    end
  end

  a_completed_sticky: assert property (
    @(posedge clk) disable iff (!reset) completed |=> completed);

  a_epsilon_bound: assert property (
    @(posedge clk) disable iff (!reset) epsilon <= epsilon_t'(`DQ_EPSILON_START));

endmodule

// ==== hw/dynaq_datapath.sv ====
`timescale 1ns/100ps

module dynaq_datapath (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          qvalue_en,
  input  logic                          reward_en,
  input  logic                          current_location_en,
  input  logic                          next_location_en,
  input  logic                          location_select,
  input  logic                          max_en,
  input  logic                          g_en,
  input  logic                          g_select,
  input  logic                          rng_en,
  input  logic                          action_en,
  input  logic                          step_en,
  input  logic                          step_select,
  input  logic                          epsilon_decay_en,
  input  logic                          episode_end,
  input  dynaq_data_pkg::location_t     start_location,
  input  dynaq_data_pkg::location_t     env_next_location,
  input  dynaq_data_pkg::qvalue_t       qvalue_0,
  input  dynaq_data_pkg::qvalue_t       qvalue_1,
  input  dynaq_data_pkg::qvalue_t       qvalue_2,
  input  dynaq_data_pkg::qvalue_t       qvalue_3,
  input  dynaq_data_pkg::reward_t       reward,
  output dynaq_data_pkg::location_t     current_location,
  output dynaq_data_pkg::location_t     next_location,
  output dynaq_policy_pkg::step_t       step_count,
  output dynaq_data_pkg::qvalue_t       qtable_data,
  output dynaq_policy_pkg::action_t     action,
  output logic                          done,
  output logic                          completed
);

  import dynaq_data_pkg::*;
  import dynaq_policy_pkg::*;

  // captured observation
  qvalue_t  q_0;
  qvalue_t  q_1;
  qvalue_t  q_2;
  qvalue_t  q_3;
  reward_t  reward_q;
  // policy side
  action_t  greedy_action;
  epsilon_t epsilon;

  state_capture u_state_capture (
    .clk                 (clk),
    .reset               (reset),
    .qvalue_en           (qvalue_en),
    .reward_en           (reward_en),
    .current_location_en (current_location_en),
    .next_location_en    (next_location_en),
    .location_select     (location_select),
    .start_location      (start_location),
    .env_next_location   (env_next_location),
    .qvalue_0            (qvalue_0),
    .qvalue_1            (qvalue_1),
    .qvalue_2            (qvalue_2),
    .qvalue_3            (qvalue_3),
    .reward              (reward),
    .current_location    (current_location),
    .next_location       (next_location),
    .q_0                 (q_0),
    .q_1                 (q_1),
    .q_2                 (q_2),
    .q_3                 (q_3),
    .reward_q            (reward_q)
  );

  q_update u_q_update (
    .clk           (clk),
    .reset         (reset),
    .max_en        (max_en),
    .g_en          (g_en),
    .g_select      (g_select),
    .q_0           (q_0),
    .q_1           (q_1),
    .q_2           (q_2),
    .q_3           (q_3),
    .reward_q      (reward_q),
    .greedy_action (greedy_action),
    .qtable_data   (qtable_data)
  );

  action_select u_action_select (
    .clk           (clk),
    .reset         (reset),
    .rng_en        (rng_en),
    .action_en     (action_en),
    .greedy_action (greedy_action),
    .epsilon       (epsilon),
    .action        (action)
  );

  episode_control u_episode_control (
    .clk              (clk),
    .reset            (reset),
    .step_en          (step_en),
    .step_select      (step_select),
    .epsilon_decay_en (epsilon_decay_en),
    .episode_end      (episode_end),
    .reward_q         (reward_q),
    .step_count       (step_count),
    .epsilon          (epsilon),
    .done             (done),
    .completed        (completed)
  );

endmodule

// ==== tests/tb_dynaq_datapath.sv ====
`timescale 1ns/100ps

`include "dynaq_params.svh"

module tb_dynaq_datapath;

  import dynaq_data_pkg::*;
  import dynaq_policy_pkg::*;

  localparam int PHASES = 6;
  localparam int PHASE_CYCLES = 400;
  // test length plus margin for reset and checks
  localparam int TIMEOUT_CYCLES = PHASES * PHASE_CYCLES + 600;

  logic      clk;
  logic      reset;
  logic      qvalue_en;
  logic      reward_en;
  logic      current_location_en;
  logic      next_location_en;
  logic      location_select;
  logic      max_en;
  logic      g_en;
  logic      g_select;
  logic      rng_en;
  logic      action_en;
  logic      step_en;
  logic      step_select;
  logic      epsilon_decay_en;
  logic      episode_end;
  location_t start_location;
  location_t env_next_location;
  qvalue_t   qvalue_0;
  qvalue_t   qvalue_1;
  qvalue_t   qvalue_2;
  qvalue_t   qvalue_3;
  reward_t   reward;
  location_t current_location;
  location_t next_location;
  step_t     step_count;
  qvalue_t   qtable_data;
  action_t   action;
  logic      done;
  logic      completed;

  // reference model state, one variable per dut register
  qvalue_t   m_q [4];
  reward_t   m_reward;
  location_t m_cur;
  location_t m_next;
  qvalue_t   m_max;
  qvalue_t   m_target;
  rand_t     m_lfsr;
  action_t   m_action;
  step_t     m_step;
  epsilon_t  m_eps;
  logic      m_completed;

  logic [31:0] rng_state = 32'h2ae;
  int          cycle_count = 0;
  logic        seen_goal_done = 1'b0;
  logic        seen_step_done = 1'b0;

  dynaq_datapath u_dut (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // small pool gives ties and negatives, wide values stress the multiply
  function automatic qvalue_t make_qvalue();
    logic [31:0] a;
    logic [31:0] b;
    a = rand32();
    b = rand32();
    if (a[31:30] == 2'b00)
      return qvalue_t'({a, b});
    return qvalue_t'($signed(a[3:0])) <<< `DQ_FRAC_W;
  endfunction

  // goal when low ten reward bits are all ones
  function automatic logic goal_of(input reward_t r);
    return &r[9:0];
  endfunction

  function automatic logic model_done();
    return goal_of(m_reward) || (step_t'(m_step + 1'b1) == step_t'(`DQ_MAX_STEPS));
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
    if (got !== expected)
      stop_with_failure($sformatf("error %s: got %h, expected %h", name, got, expected));
  endtask

  task automatic model_reset();
    for (int k = 0; k < 4; k++)
      m_q[k] = '0;
    m_reward    = '0;
    m_cur       = '0;
    m_next      = '0;
    m_max       = '0;
    m_target    = '0;
    m_lfsr      = rand_t'(1);
    m_action    = '0;
    m_step      = '0;
    m_eps       = epsilon_t'(120);
    m_completed = 1'b0;
  endtask

  // one rising edge of every register, old values read before any update
  task automatic model_step();
    qvalue_t best;
    action_t best_idx;
    qvalue_t r_ext;
    logic    now_done;
    int      k;
    logic signed [2*`DQ_DATA_W-1:0] wide;
    best     = m_q[0];
    best_idx = 2'd0;
    for (k = 1; k < 4; k++) begin
      if (m_q[k] > best) begin
        best     = m_q[k];
        best_idx = action_t'(k);
      end
    end
    now_done = model_done();
    if (episode_end && (m_eps == '0) && now_done)
      m_completed = 1'b1;
    if (action_en)
      m_action = (m_lfsr[6:0] < m_eps) ? m_lfsr[8:7] : best_idx;
    if (epsilon_decay_en && goal_of(m_reward))
      m_eps = (m_eps < 10) ? '0 : m_eps - 10;
    if (rng_en)
      m_lfsr = {m_lfsr[15:0], m_lfsr[16] ^ m_lfsr[13]};
    if (step_en)
      m_step = step_select ? step_t'(m_step + 1'b1) : '0;
    if (g_en && g_select) begin
      r_ext    = m_reward;
      m_target = (r_ext <<< 16) + m_target;
    end else if (g_en) begin
      // q16 multiply by gamma, back to q16
      wide     = m_max;
      wide     = wide * `DQ_GAMMA;
      wide     = wide >>> 16;
      m_target = wide[63:0];
    end
    if (max_en)
      m_max = best;
    if (qvalue_en) begin
      m_q[0] = qvalue_0;
      m_q[1] = qvalue_1;
      m_q[2] = qvalue_2;
      m_q[3] = qvalue_3;
    end
    if (reward_en)
      m_reward = reward;
    // current reads the old next location
    if (current_location_en)
      m_cur = location_select ? m_next : start_location;
    if (next_location_en)
      m_next = location_select ? env_next_location : start_location;
  endtask

  task automatic check_outputs();
    check("current_location", current_location, m_cur);
    check("next_location", next_location, m_next);
    check("step_count", step_count, m_step);
    check("qtable_data", qtable_data, m_target);
    check("action", action, m_action);
    check("epsilon", u_dut.epsilon, m_eps);
    check("done", done, model_done());
    check("completed", completed, m_completed);
    if (model_done() && goal_of(m_reward))
      seen_goal_done = 1'b1;
    if (model_done() && m_step == step_t'(1022))
      seen_step_done = 1'b1;
  endtask

  // phases 1-3 count steps up to the limit, 4 adds clears,
  // 5 decays epsilon on goal rewards, 6 adds episode_end
  task automatic drive_inputs(input int phase);
    logic [31:0] r;
    logic [31:0] s;
    logic        force_goal;
    r = rand32();
    s = rand32();
    qvalue_0 = make_qvalue();
    qvalue_1 = make_qvalue();
    qvalue_2 = make_qvalue();
    qvalue_3 = make_qvalue();
    start_location    = location_t'(s[5:0]);
    env_next_location = location_t'(s[11:6]);
    force_goal = (phase >= 5) ? (s[14:12] != 3'd0) : (phase == 4 && s[14:13] == 2'd0);
    if (force_goal)
      reward = s[15] ? reward_t'(11'h3ff) : reward_t'(11'h7ff);
    else
      reward = reward_t'(s[26:16]);
    qvalue_en           = r[0];
    max_en              = r[1];
    g_en                = r[2];
    g_select            = r[3];
    reward_en           = r[4];
    current_location_en = r[5];
    next_location_en    = r[6];
    location_select     = r[7];
    rng_en              = r[8];
    action_en           = r[9];
    step_en             = (phase <= 3) ? 1'b1 : r[10];
    // clear about one time in sixteen
    step_select         = (phase <= 3) ? 1'b1 : |r[14:11];
    epsilon_decay_en    = (phase >= 5) ? r[15] : 1'b0;
    episode_end         = (phase == 6) ? r[16] : 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_with_failure($sformatf("timeout: run still going after %0d cycles", cycle_count));
  end

  initial begin
    reset = 1'b0;
    qvalue_en = 1'b0;
    reward_en = 1'b0;
    current_location_en = 1'b0;
    next_location_en = 1'b0;
    location_select = 1'b0;
    max_en = 1'b0;
    g_en = 1'b0;
    g_select = 1'b0;
    rng_en = 1'b0;
    action_en = 1'b0;
    step_en = 1'b0;
    step_select = 1'b0;
    epsilon_decay_en = 1'b0;
    episode_end = 1'b0;
    start_location = '0;
    env_next_location = '0;
    qvalue_0 = '0;
    qvalue_1 = '0;
    qvalue_2 = '0;
    qvalue_3 = '0;
    reward = '0;
    model_reset();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b1;
    // reset values before any strobe
    check_outputs();
    for (int phase = 1; phase <= PHASES; phase++) begin
      for (int i = 0; i < PHASE_CYCLES; i++) begin
        drive_inputs(phase);
        @(posedge clk);
        model_step();
        @(negedge clk);
        check_outputs();
      end
    end
    if (!seen_goal_done || !seen_step_done || !m_completed) begin
      stop_with_failure("run ended without goal done, last-step done and completed all seen");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
+incdir+include
hw/dynaq_data_pkg.sv
hw/dynaq_policy_pkg.sv
hw/state_capture.sv
hw/q_update.sv
hw/action_select.sv
hw/episode_control.sv
hw/dynaq_datapath.sv
tests/tb_dynaq_datapath.sv

// ==== Bender.yml ====
package:
  name: dynaq_datapath

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/dynaq_data_pkg.sv
      - hw/dynaq_policy_pkg.sv
      - hw/state_capture.sv
      - hw/q_update.sv
      - hw/action_select.sv
      - hw/episode_control.sv
      - hw/dynaq_datapath.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_dynaq_datapath.sv
